// File: rtl/mipsPkg.sv
`default_nettype none

package mipsPkg;

	// Core constants
	localparam logic [31:0] resetPc = 32'h0000_3000;
	localparam int dataWords = 1024;

	// Primary opcodes
	localparam logic [5:0] opSpecial = 6'h00;
	localparam logic [5:0] opJ = 6'h02;
	localparam logic [5:0] opJal = 6'h03;
	localparam logic [5:0] opBeq = 6'h04;
	localparam logic [5:0] opOri = 6'h0d;
	localparam logic [5:0] opLui = 6'h0f;
	localparam logic [5:0] opLw = 6'h23;
	localparam logic [5:0] opSw = 6'h2b;

	// Funct codes under opSpecial
	localparam logic [5:0] fnAddu = 6'h21;
	localparam logic [5:0] fnSubu = 6'h23;

	// Zero encodings are the inactive ones, so a cleared payload is a bubble
	typedef enum logic [1:0] {aluAdd, aluSub, aluOr, aluLui} aluOpT;
	typedef enum logic [1:0] {fwdReg, fwdMem, fwdWb} fwdSelT;
	typedef enum logic [1:0] {wbAlu, wbMem, wbLink} wbSelT;

	typedef struct packed {
		logic regWrite;
		logic memWrite;
		logic memRead;
		aluOpT aluOp;
		logic aluSrcImm;
		logic zeroExt;
		wbSelT wbSel;
		logic isBranch;
		logic isJump;
	} ctrlT;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] instr;
	} ifIdT;

	typedef struct packed {
		logic [31:0] pc;
		ctrlT ctrl;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] dest;
		logic [31:0] rsVal;
		logic [31:0] rtVal;
		logic [31:0] imm;
	} idExT;

	typedef struct packed {
		logic [31:0] pc;
		ctrlT ctrl;
		logic [4:0] rt;
		logic [4:0] dest;
		logic [31:0] aluResult;
		logic [31:0] storeVal;
	} exMemT;

	typedef struct packed {
		logic [31:0] pc;
		ctrlT ctrl;
		logic [4:0] dest;
		logic [31:0] aluResult;
		logic [31:0] readData;
	} memWbT;

	// Retirement events
	typedef struct packed {
		logic valid;
		logic [4:0] regNum;
		logic [31:0] data;
	} regWrEventT;

	typedef struct packed {
		logic valid;
		logic [31:0] addr;
		logic [31:0] data;
	} memWrEventT;

endpackage

`default_nettype wire

// File: rtl/instrFetch.sv
`default_nettype none

module instrFetch (
	input logic clk,
	input logic rst,
	input logic stall,
	input logic takeBranch,
	input logic takeJump,
	input logic [15:0] branchOffset,
	input logic [25:0] jumpIndex,
	output logic [31:0] pc
);

	logic [31:0] branchTarget;
	logic [31:0] jumpTarget;
	logic [31:0] pcNext;

	// Current pc is already the delay slot when decode resolves
	assign branchTarget = pc + {{14{branchOffset[15]}}, branchOffset, 2'b00};
	assign jumpTarget = {pc[31:28], jumpIndex, 2'b00};

	always_comb begin
		if (stall) begin
			pcNext = pc;
		end else if (takeBranch) begin
			pcNext = branchTarget;
		end else if (takeJump) begin
			pcNext = jumpTarget;
		end else begin
			pcNext = pc + 32'd4;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= mipsPkg::resetPc;
		end else begin
			pc <= pcNext;
		end
	end

endmodule

`default_nettype wire

// File: rtl/pipeReg.sv
`default_nettype none

module pipeReg #(
	parameter type payloadT = logic [31:0]
) (
	input logic clk,
	input logic rst,
	input logic en,
	input logic bubble,
	input payloadT d,
	output payloadT q
);

	// All-zero payload leaves every control field inactive
	always_ff @(posedge clk) begin
		if (rst || bubble) begin
			q <= '0;
		end else if (en) begin
			q <= d;
		end
	end

endmodule

`default_nettype wire

// File: rtl/ctrlDecode.sv
`default_nettype none

module ctrlDecode (
	input logic [31:0] instr,
	output mipsPkg::ctrlT ctrl,
	output logic [4:0] dest
);

	logic [5:0] op;
	logic [5:0] fn;
	logic [4:0] rawDest;

	assign op = instr[31:26];
	assign fn = instr[5:0];

	always_comb begin
		ctrl = '0;
		rawDest = instr[20:16];
		case (op)
			mipsPkg::opSpecial: begin
				rawDest = instr[15:11];
				if (fn == mipsPkg::fnAddu) begin
					ctrl.regWrite = 1'b1;
				end else if (fn == mipsPkg::fnSubu) begin
					ctrl.regWrite = 1'b1;
					ctrl.aluOp = mipsPkg::aluSub;
				end
			end
			mipsPkg::opOri: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluOp = mipsPkg::aluOr;
				ctrl.aluSrcImm = 1'b1;
				ctrl.zeroExt = 1'b1;
			end
			mipsPkg::opLui: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluOp = mipsPkg::aluLui;
				ctrl.aluSrcImm = 1'b1;
			end
			mipsPkg::opLw: begin
				ctrl.regWrite = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.wbSel = mipsPkg::wbMem;
			end
			mipsPkg::opSw: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
			end
			mipsPkg::opBeq: ctrl.isBranch = 1'b1;
			mipsPkg::opJ: ctrl.isJump = 1'b1;
			mipsPkg::opJal: begin
				ctrl.isJump = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.wbSel = mipsPkg::wbLink;
				rawDest = 5'd31;
			end
			// Anything else stays a no-op
			default: ;
		endcase
	end

	// Non-writing instructions carry dest 0 down the pipe
	assign dest = ctrl.regWrite ? rawDest : 5'd0;

endmodule

`default_nettype wire

// File: rtl/regFile.sv
`default_nettype none

module regFile (
	input logic clk,
	input logic rst,
	input logic we,
	input logic [4:0] wa,
	input logic [31:0] wd,
	input logic [4:0] ra1,
	input logic [4:0] ra2,
	output logic [31:0] rd1,
	output logic [31:0] rd2
);

	logic [31:0] regs [32];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && wa != 5'd0) begin
			regs[wa] <= wd;
		end
	end

	// Same-cycle writeback value is visible to decode
	always_comb begin
		if (ra1 == 5'd0) begin
			rd1 = '0;
		end else if (we && ra1 == wa) begin
			rd1 = wd;
		end else begin
			rd1 = regs[ra1];
		end
		if (ra2 == 5'd0) begin
			rd2 = '0;
		end else if (we && ra2 == wa) begin
			rd2 = wd;
		end else begin
			rd2 = regs[ra2];
		end
	end

endmodule

`default_nettype wire

// File: rtl/hazardCtrl.sv
`default_nettype none

module hazardCtrl (
	input logic [31:0] decInstr,
	input mipsPkg::ctrlT decCtrl,
	input mipsPkg::idExT idEx,
	input mipsPkg::exMemT exMem,
	input mipsPkg::memWbT memWb,
	output logic stall,
	output mipsPkg::fwdSelT decFwdA,
	output mipsPkg::fwdSelT decFwdB,
	output mipsPkg::fwdSelT exFwdA,
	output mipsPkg::fwdSelT exFwdB
);

	logic [5:0] op;
	logic [5:0] fn;
	logic [4:0] rs;
	logic [4:0] rt;
	logic useRs;
	logic useRt;
	logic exHit;
	logic memLoadHit;
	logic memFwdOk;
	logic wbFwdOk;

	assign op = decInstr[31:26];
	assign fn = decInstr[5:0];
	assign rs = decInstr[25:21];
	assign rt = decInstr[20:16];

	// Which source fields the decode instruction actually reads
	always_comb begin
		useRs = 1'b0;
		useRt = 1'b0;
		case (op)
			mipsPkg::opSpecial: begin
				useRs = (fn == mipsPkg::fnAddu) || (fn == mipsPkg::fnSubu);
				useRt = useRs;
			end
			mipsPkg::opOri, mipsPkg::opLw: useRs = 1'b1;
			mipsPkg::opSw, mipsPkg::opBeq: begin
				useRs = 1'b1;
				useRt = 1'b1;
			end
			default: ;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Stall detection

	// dest is 0 for non-writing instructions
	assign exHit = (idEx.dest != 5'd0) &&
		((useRs && idEx.dest == rs) || (useRt && idEx.dest == rt));
	assign memLoadHit = exMem.ctrl.memRead && (exMem.dest != 5'd0) &&
		((useRs && exMem.dest == rs) || (useRt && exMem.dest == rt));

	assign stall = (idEx.ctrl.memRead && exHit) ||
		(decCtrl.isBranch && exHit) ||
		(decCtrl.isBranch && memLoadHit);

	////////////////////////////////////////////////////////////////////////////
	// Forwarding selects with the memory stage first

	// Loads in memory are excluded since the stall covers them
	assign memFwdOk = exMem.ctrl.regWrite && !exMem.ctrl.memRead && exMem.dest != 5'd0;
	assign wbFwdOk = memWb.ctrl.regWrite && memWb.dest != 5'd0;

	assign decFwdA = (memFwdOk && exMem.dest == rs) ? mipsPkg::fwdMem : mipsPkg::fwdReg;
	assign decFwdB = (memFwdOk && exMem.dest == rt) ? mipsPkg::fwdMem : mipsPkg::fwdReg;

	assign exFwdA = (memFwdOk && exMem.dest == idEx.rs) ? mipsPkg::fwdMem :
		(wbFwdOk && memWb.dest == idEx.rs) ? mipsPkg::fwdWb : mipsPkg::fwdReg;
	assign exFwdB = (memFwdOk && exMem.dest == idEx.rt) ? mipsPkg::fwdMem :
		(wbFwdOk && memWb.dest == idEx.rt) ? mipsPkg::fwdWb : mipsPkg::fwdReg;

endmodule

`default_nettype wire

// File: rtl/execAlu.sv
`default_nettype none

module execAlu (
	input mipsPkg::aluOpT aluOp,
	input logic [31:0] a,
	input logic [31:0] b,
	output logic [31:0] y
);

	// Unsigned wrap on add and subtract
	always_comb begin
		case (aluOp)
			mipsPkg::aluAdd: y = a + b;
			mipsPkg::aluSub: y = a - b;
			mipsPkg::aluOr: y = a | b;
			mipsPkg::aluLui: y = {b[15:0], 16'h0000};
			default: y = a + b;
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/dataMem.sv
`default_nettype none

module dataMem (
	input logic clk,
	input logic we,
	input logic [31:0] addr,
	input logic [31:0] wd,
	output logic [31:0] rd
);

	logic [31:0] mem [mipsPkg::dataWords];
	logic [9:0] wordIdx;

	initial begin
		for (int i = 0; i < mipsPkg::dataWords; i++) begin
			mem[i] = '0;
		end
	end

	// Byte address with word granularity
	assign wordIdx = addr[11:2];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[wordIdx] <= wd;
		end
	end

	assign rd = mem[wordIdx];

endmodule

`default_nettype wire

// File: rtl/mipsCore.sv
`default_nettype none

module mipsCore (
	input logic clk,
	input logic rst,
	output logic [31:0] imemAddr,
	input logic [31:0] imemData,
	output mipsPkg::regWrEventT regWrEvent,
	output mipsPkg::memWrEventT memWrEvent
);

	mipsPkg::ifIdT ifIdNext;
	mipsPkg::ifIdT ifId;
	mipsPkg::idExT idExNext;
	mipsPkg::idExT idEx;
	mipsPkg::exMemT exMemNext;
	mipsPkg::exMemT exMem;
	mipsPkg::memWbT memWbNext;
	mipsPkg::memWbT memWb;

	mipsPkg::ctrlT decCtrl;
	logic [4:0] decDest;
	logic [31:0] rfA;
	logic [31:0] rfB;
	logic [31:0] decA;
	logic [31:0] decB;
	logic [31:0] decImm;
	logic takeBranch;
	logic stall;
	mipsPkg::fwdSelT decFwdA;
	mipsPkg::fwdSelT decFwdB;
	mipsPkg::fwdSelT exFwdA;
	mipsPkg::fwdSelT exFwdB;

	logic [31:0] exA;
	logic [31:0] exB;
	logic [31:0] aluB;
	logic [31:0] aluY;
	logic [31:0] memReadData;
	logic [31:0] memFwdVal;
	logic [31:0] wbData;

	////////////////////////////////////////////////////////////////////////////
	// Fetch

	instrFetch uFetch (
		.clk(clk),
		.rst(rst),
		.stall(stall),
		.takeBranch(takeBranch),
		.takeJump(decCtrl.isJump),
		.branchOffset(ifId.instr[15:0]),
		.jumpIndex(ifId.instr[25:0]),
		.pc(imemAddr)
	);

	assign ifIdNext = '{pc: imemAddr, instr: imemData};

	pipeReg #(.payloadT(mipsPkg::ifIdT)) uIfId (
		.clk(clk), .rst(rst), .en(!stall), .bubble(1'b0), .d(ifIdNext), .q(ifId)
	);

	////////////////////////////////////////////////////////////////////////////
	// Decode

	ctrlDecode uDecode (
		.instr(ifId.instr),
		.ctrl(decCtrl),
		.dest(decDest)
	);

	regFile uRegs (
		.clk(clk),
		.rst(rst),
		.we(memWb.ctrl.regWrite),
		.wa(memWb.dest),
		.wd(wbData),
		.ra1(ifId.instr[25:21]),
		.ra2(ifId.instr[20:16]),
		.rd1(rfA),
		.rd2(rfB)
	);

	hazardCtrl uHazard (
		.decInstr(ifId.instr),
		.decCtrl(decCtrl),
		.idEx(idEx),
		.exMem(exMem),
		.memWb(memWb),
		.stall(stall),
		.decFwdA(decFwdA),
		.decFwdB(decFwdB),
		.exFwdA(exFwdA),
		.exFwdB(exFwdB)
	);

	// Writeback arrives through the register file bypass
	assign decA = (decFwdA == mipsPkg::fwdMem) ? memFwdVal : rfA;
	assign decB = (decFwdB == mipsPkg::fwdMem) ? memFwdVal : rfB;
	assign takeBranch = decCtrl.isBranch && (decA == decB);

	assign decImm = decCtrl.zeroExt ? {16'h0000, ifId.instr[15:0]} :
		{{16{ifId.instr[15]}}, ifId.instr[15:0]};

	assign idExNext = '{
		pc: ifId.pc,
		ctrl: decCtrl,
		rs: ifId.instr[25:21],
		rt: ifId.instr[20:16],
		dest: decDest,
		rsVal: decA,
		rtVal: decB,
		imm: decImm
	};

	pipeReg #(.payloadT(mipsPkg::idExT)) uIdEx (
		.clk(clk), .rst(rst), .en(1'b1), .bubble(stall), .d(idExNext), .q(idEx)
	);

	////////////////////////////////////////////////////////////////////////////
	// Execute

	always_comb begin
		case (exFwdA)
			mipsPkg::fwdMem: exA = memFwdVal;
			mipsPkg::fwdWb: exA = wbData;
			default: exA = idEx.rsVal;
		endcase
		case (exFwdB)
			mipsPkg::fwdMem: exB = memFwdVal;
			mipsPkg::fwdWb: exB = wbData;
			default: exB = idEx.rtVal;
		endcase
	end

	assign aluB = idEx.ctrl.aluSrcImm ? idEx.imm : exB;

	execAlu uAlu (
		.aluOp(idEx.ctrl.aluOp),
		.a(exA),
		.b(aluB),
		.y(aluY)
	);

	assign exMemNext = '{
		pc: idEx.pc,
		ctrl: idEx.ctrl,
		rt: idEx.rt,
		dest: idEx.dest,
		aluResult: aluY,
		storeVal: exB
	};

	pipeReg #(.payloadT(mipsPkg::exMemT)) uExMem (
		.clk(clk), .rst(rst), .en(1'b1), .bubble(1'b0), .d(exMemNext), .q(exMem)
	);

	////////////////////////////////////////////////////////////////////////////
	// Memory

	dataMem uDmem (
		.clk(clk),
		.we(exMem.ctrl.memWrite),
		.addr(exMem.aluResult),
		.wd(exMem.storeVal),
		.rd(memReadData)
	);

	// A jal in memory forwards its link address instead of the ALU output
	assign memFwdVal = (exMem.ctrl.wbSel == mipsPkg::wbLink) ? exMem.pc + 32'd8 :
		exMem.aluResult;

	assign memWbNext = '{
		pc: exMem.pc,
		ctrl: exMem.ctrl,
		dest: exMem.dest,
		aluResult: exMem.aluResult,
		readData: memReadData
	};

	pipeReg #(.payloadT(mipsPkg::memWbT)) uMemWb (
		.clk(clk), .rst(rst), .en(1'b1), .bubble(1'b0), .d(memWbNext), .q(memWb)
	);

	////////////////////////////////////////////////////////////////////////////
	// Writeback and retirement events

	always_comb begin
		case (memWb.ctrl.wbSel)
			mipsPkg::wbMem: wbData = memWb.readData;
			mipsPkg::wbLink: wbData = memWb.pc + 32'd8;
			default: wbData = memWb.aluResult;
		endcase
	end

	assign regWrEvent = '{
		valid: memWb.ctrl.regWrite && (memWb.dest != 5'd0),
		regNum: memWb.dest,
		data: wbData
	};

	// Store commits at the memory stage edge
	assign memWrEvent = '{
		valid: exMem.ctrl.memWrite,
		addr: exMem.aluResult,
		data: exMem.storeVal
	};

endmodule

`default_nettype wire

// File: test/mipsCore_props.sv
`default_nettype none

module mipsCore_props (
	input logic clk,
	input logic rst,
	input mipsPkg::regWrEventT regWrEvent,
	input mipsPkg::memWrEventT memWrEvent
);

	timeunit 1ns;
	timeprecision 1ps;

	logic anyEvent;

	assign anyEvent = regWrEvent.valid || memWrEvent.valid;

	// Register 0 writes never leave the core
	regNotZero: assert property (@(posedge clk) disable iff (rst)
		regWrEvent.valid |-> regWrEvent.regNum != 5'd0)
		else $error("regWrEvent targets register 0");

	storeAligned: assert property (@(posedge clk) disable iff (rst)
		memWrEvent.valid |-> memWrEvent.addr[1:0] == 2'b00)
		else $error("memWrEvent address %h is not word aligned", memWrEvent.addr);

	// Pipeline is still filling for 4 cycles after reset release
	quietAfterReset: assert property (@(posedge clk)
		($past(rst, 1) || $past(rst, 2) || $past(rst, 3) || $past(rst, 4)) |-> !anyEvent)
		else $error("Event valid within 4 cycles of reset release");

endmodule

bind mipsCore mipsCore_props uProps (
	.clk(clk),
	.rst(rst),
	.regWrEvent(regWrEvent),
	.memWrEvent(memWrEvent)
);

`default_nettype wire

// File: test/mipsCore_tb.sv
`default_nettype none

module mipsCore_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int clkPeriod = 20;
	localparam int imemWords = 256;
	localparam int idleCycles = 20;
	localparam string goldenPath = "test/mipsCore_golden.txt";

	logic clk = 1'b0;
	logic rst;
	logic [31:0] imemAddr;
	logic [31:0] imemData;
	mipsPkg::regWrEventT regWrEvent;
	mipsPkg::memWrEventT memWrEvent;

	// Program image with one slot per word from the reset PC upward
	logic [31:0] imem [imemWords];
	bit imemValid [imemWords];
	logic [31:0] fetchOffset;
	int progWords = 0;
	bit loaded = 1'b0;

	// Expected retirements in program order
	mipsPkg::regWrEventT regQ [$];
	mipsPkg::memWrEventT memQ [$];

	always #(clkPeriod / 2) clk = ~clk;

	mipsCore UUT (
		.clk(clk),
		.rst(rst),
		.imemAddr(imemAddr),
		.imemData(imemData),
		.regWrEvent(regWrEvent),
		.memWrEvent(memWrEvent)
	);

	// Combinational fetch port where unloaded words jump to themselves
	always_comb begin
		fetchOffset = imemAddr - mipsPkg::resetPc;
		if (fetchOffset[31:10] == 22'd0 && imemValid[fetchOffset[9:2]]) begin
			imemData = imem[fetchOffset[9:2]];
		end else begin
			imemData = {mipsPkg::opJ, imemAddr[27:2]};
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Failure reporting and comparison

	task automatic failRun(string why);
		$display("%s", why);
		$display("TB FAILED");
		$fatal(1, "Simulation stopped on a failed check");
	endtask

	task automatic compareValue(string name, logic [31:0] expVal, logic [31:0] gotVal);
		assert (gotVal == expVal) else begin
			failRun($sformatf("Error at %0t: %s expected %h, got %h",
				$time, name, expVal, gotVal));
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Golden file loader

	// Records hold a kind letter and two hex fields while # opens a comment
	task automatic loadGolden();
		int fd;
		int code;
		logic [7:0] kind;
		logic [31:0] first;
		logic [31:0] second;
		logic [31:0] offset;
		logic [8*128-1:0] rest;
		mipsPkg::regWrEventT expReg;
		mipsPkg::memWrEventT expMem;
		fd = $fopen(goldenPath, "r");
		assert (fd != 0) else begin
			failRun("Could not open the golden file test/mipsCore_golden.txt");
		end
		code = $fscanf(fd, " %c", kind);
		while (code == 1) begin
			if (kind == "#") begin
				code = $fgets(rest, fd);
			end else begin
				code = $fscanf(fd, "%h %h", first, second);
				assert (code == 2) else begin
					failRun("A record in the golden file is missing a field");
				end
				case (kind)
					"I": begin
						offset = first - mipsPkg::resetPc;
						assert (offset[31:10] == 22'd0 && offset[1:0] == 2'b00) else begin
							failRun($sformatf("Program address %h is outside the image",
								first));
						end
						imem[offset[9:2]] = second;
						imemValid[offset[9:2]] = 1'b1;
						progWords++;
					end
					"R": begin
						expReg.valid = 1'b1;
						expReg.regNum = first[4:0];
						expReg.data = second;
						regQ.push_back(expReg);
					end
					"M": begin
						expMem.valid = 1'b1;
						expMem.addr = first;
						expMem.data = second;
						memQ.push_back(expMem);
					end
					default: begin
						failRun($sformatf("Unknown record kind %s in the golden file", kind));
					end
				endcase
			end
			code = $fscanf(fd, " %c", kind);
		end
		$fclose(fd);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Retirement checks

	task automatic checkEvents();
		mipsPkg::regWrEventT expReg;
		mipsPkg::memWrEventT expMem;
		if (regWrEvent.valid) begin
			assert (regQ.size() != 0) else begin
				failRun("A register write retired after all expected writes were seen");
			end
			expReg = regQ.pop_front();
			compareValue("regWrEvent.regNum", {27'd0, expReg.regNum},
				{27'd0, regWrEvent.regNum});
			compareValue("regWrEvent.data", expReg.data, regWrEvent.data);
		end
		if (memWrEvent.valid) begin
			assert (memQ.size() != 0) else begin
				failRun("A memory write committed after all expected writes were seen");
			end
			expMem = memQ.pop_front();
			compareValue("memWrEvent.addr", expMem.addr, memWrEvent.addr);
			compareValue("memWrEvent.data", expMem.data, memWrEvent.data);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		int idle;
		rst = 1'b1;
		loadGolden();
		loaded = 1'b1;
		repeat (2) @(negedge clk);
		rst = 1'b0;
		// Fetch starts from the reset PC
		compareValue("imemAddr", mipsPkg::resetPc, imemAddr);
		// Events come from registered stages and are stable at the rising edge
		idle = 0;
		while (idle < idleCycles) begin
			@(posedge clk);
			checkEvents();
			if (regQ.size() == 0 && memQ.size() == 0) begin
				idle++;
			end
		end
		$display("TB PASSED");
		$finish;
	end

	// Budget scales with the program length
	initial begin
		wait (loaded);
		#(20 * (progWords + 10) * clkPeriod);
		failRun($sformatf("Timeout with %0d register and %0d memory writes still pending",
			regQ.size(), memQ.size()));
	end

endmodule

`default_nettype wire

// File: test/mipsCore_golden.txt
# I address word : program image, R reg value : register write, M address value : memory write
# All fields hex, R and M records in retirement order
I 00003000 34011234  # ori r1, r0, 0x1234
I 00003004 3c02ffff  # lui r2, 0xffff
I 00003008 00221821  # addu r3, r1, r2
I 0000300c 00612023  # subu r4, r3, r1
I 00003010 00232823  # subu r5, r1, r3
I 00003014 34a600ff  # ori r6, r5, 0xff
I 00003018 ac060100  # sw r6, 0x100(r0)
I 0000301c 8c070100  # lw r7, 0x100(r0)
I 00003020 00e74021  # addu r8, r7, r7
I 00003024 01080021  # addu r0, r8, r8
I 00003028 11000004  # beq r8, r0 not taken
I 0000302c 34090009  # ori r9, r0, 9
I 00003030 340a0009  # ori r10, r0, 9
I 00003034 11490002  # beq r10, r9 taken after stall
I 00003038 340b000b  # ori r11, r0, 0xb
I 0000303c 340cdead  # skipped
I 00003040 08000c14  # j 0x3050
I 00003044 340d000d  # ori r13, r0, 0xd
I 00003048 340cbeef  # skipped
I 0000304c 340cbeef  # skipped
I 00003050 0c000c18  # jal 0x3060
I 00003054 340e000e  # ori r14, r0, 0xe
I 00003058 340cbeef  # skipped
I 0000305c 340cbeef  # skipped
I 00003060 03e07821  # addu r15, r31, r0
I 00003064 8c100100  # lw r16, 0x100(r0)
I 00003068 12060002  # beq r16, r6 taken after load stall
I 0000306c ac100104  # sw r16, 0x104(r0)
I 00003070 340cbeef  # skipped
I 00003074 10010002  # beq r0, r1 not taken
I 00003078 ac030108  # sw r3, 0x108(r0)
I 0000307c 00828823  # subu r17, r4, r2
I 00003080 3c128000  # lui r18, 0x8000
I 00003084 02529821  # addu r19, r18, r18
I 00003088 08000c22  # j 0x3088
I 0000308c 00000000  # nop
R 01 00001234
R 02 ffff0000
R 03 ffff1234
R 04 ffff0000
R 05 00010000
R 06 000100ff
R 07 000100ff
R 08 000201fe
R 09 00000009
R 0a 00000009
R 0b 0000000b
R 0d 0000000d
R 1f 00003058
R 0e 0000000e
R 0f 00003058
R 10 000100ff
R 11 00000000
R 12 80000000
R 13 00000000
M 00000100 000100ff
M 00000104 000100ff
M 00000108 ffff1234

// File: tb.f
rtl/mipsPkg.sv
rtl/instrFetch.sv
rtl/pipeReg.sv
rtl/ctrlDecode.sv
rtl/regFile.sv
rtl/hazardCtrl.sv
rtl/execAlu.sv
rtl/dataMem.sv
rtl/mipsCore.sv
test/mipsCore_props.sv
test/mipsCore_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module mipsCore_tb -f tb.f -o simv

output=$(./obj_dir/simv 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "TB PASSED"; then
	exit 0
else
	exit 1
fi
